/* Bender.yml */
package:
  name: mc_node

sources:
  - include_dirs:
      - source
    files:
      - source/mc_pkt_pkg.sv
      - source/mc_cfg_pkg.sv
      - source/mc_fifo.sv
      - source/mc_endpoint.sv
      - source/mc_node_csr.sv
      - source/mc_injector.sv
      - source/mc_store.sv
      - source/mc_node_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/mc_node_properties.sv
      - tests/mc_node_tb.sv

/* source/mc_cfg_pkg.sv */
`include "mc_defs.svh"

package mc_cfg_pkg;

   // store command queued by the host
   typedef struct packed {
      logic [`MC_Y_W-1:0]    y_cord;
      logic [`MC_X_W-1:0]    x_cord;
      logic [`MC_ADDR_W-1:0] addr;
      logic [`MC_DATA_W-1:0] data;
   } mc_host_cmd_s;

   typedef enum logic [0:0] {
      MC_CSR_CORD   = 1'b0,
      MC_CSR_CREDIT = 1'b1
   } mc_csr_addr_e;

endpackage

/* source/mc_defs.svh */
`ifndef MC_DEFS_SVH
`define MC_DEFS_SVH

// node coordinate widths
`define MC_X_W 3
`define MC_Y_W 3

// local word address and data
`define MC_ADDR_W 4
`define MC_DATA_W 32

// queue depths
`define MC_IN_ELS  2
`define MC_CMD_ELS 4

// outstanding credit counter, limit is at most 7
`define MC_CREDIT_W 3

`endif

/* source/mc_endpoint.sv */
`timescale 1ns/10ps
`include "mc_defs.svh"

module mc_endpoint (
   input  logic                       clk_i,
   input  logic                       reset_i,
   // forward link, incoming side
   input  logic                       link_fwd_v_i,
   input  mc_pkt_pkg::mc_packet_s     link_fwd_data_i,
   output logic                       link_fwd_ready_o,
   // forward link, outgoing side
   output logic                       link_fwd_v_o,
   output mc_pkt_pkg::mc_packet_s     link_fwd_data_o,
   input  logic                       link_fwd_ready_i,
   // reverse link
   input  logic                       link_rev_v_i,
   input  logic                       link_rev_ready_i,
   output logic                       link_rev_v_o,
   output mc_pkt_pkg::mc_return_pkt_s link_rev_data_o,
   // local incoming requests
   output logic                       fifo_v_o,
   output mc_pkt_pkg::mc_packet_s     fifo_data_o,
   input  logic                       fifo_yumi_i,
   // local outgoing packets
   input  logic                       out_v_i,
   input  mc_pkt_pkg::mc_packet_s     out_packet_i,
   output logic                       out_ready_o,
   output logic                       credit_v_o
);
   import mc_pkt_pkg::*;

   logic fifo_v;
   logic credit_v_r;

   mc_fifo #(.payload_t(mc_packet_s), .els_p(`MC_IN_ELS)) u_in_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (link_fwd_v_i),
      .data_i  (link_fwd_data_i),
      .ready_o (link_fwd_ready_o),
      .v_o     (fifo_v),
      .data_o  (fifo_data_o),
      .yumi_i  (fifo_yumi_i)
   );

   // requests stay hidden while the mesh cannot take a credit
   assign fifo_v_o = fifo_v & link_rev_ready_i;

   // one credit per consumed request
   assign link_rev_v_o    = fifo_yumi_i;
   assign link_rev_data_o = fifo_data_o.return_pkt;

   assign link_fwd_v_o    = out_v_i;
   assign link_fwd_data_o = out_packet_i;
   assign out_ready_o     = link_fwd_ready_i;

   always_ff @(posedge clk_i) begin
      if (reset_i)
         credit_v_r <= 1'b0;
      else
         credit_v_r <= link_rev_v_i;
   end

   assign credit_v_o = credit_v_r;

endmodule

/* source/mc_fifo.sv */
`timescale 1ns/10ps

module mc_fifo #(
   parameter type payload_t = logic [31:0],
   parameter int  els_p     = 2
) (
   input  logic     clk_i,
   input  logic     reset_i,
   input  logic     v_i,
   input  payload_t data_i,
   output logic     ready_o,
   output logic     v_o,
   output payload_t data_o,
   input  logic     yumi_i
);

   localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
   localparam int cnt_w_lp = $clog2(els_p + 1);

   payload_t            mem_r [els_p];
   logic [ptr_w_lp-1:0] wptr_r;
   logic [ptr_w_lp-1:0] rptr_r;
   logic [cnt_w_lp-1:0] count_r;
   logic                enq;

   // wrap at els_p, depth need not be a power of two
   function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] ptr);
      return (ptr == ptr_w_lp'(els_p - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign ready_o = (count_r != cnt_w_lp'(els_p));
   assign v_o     = (count_r != '0);
   assign data_o  = mem_r[rptr_r];
   assign enq     = v_i & ready_o;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wptr_r  <= '0;
         rptr_r  <= '0;
         count_r <= '0;
      end else begin
         if (enq)
            wptr_r <= next_ptr(wptr_r);
         if (yumi_i)
            rptr_r <= next_ptr(rptr_r);
         count_r <= count_r + cnt_w_lp'(enq) - cnt_w_lp'(yumi_i);
      end
   end

   always_ff @(posedge clk_i) begin
      if (enq)
         mem_r[wptr_r] <= data_i;
   end

endmodule

/* source/mc_injector.sv */
`timescale 1ns/10ps
`include "mc_defs.svh"

module mc_injector (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  logic                      cmd_v_i,
   input  mc_cfg_pkg::mc_host_cmd_s  cmd_i,
   output logic                      cmd_ready_o,
   input  logic [`MC_X_W-1:0]        own_x_i,
   input  logic [`MC_Y_W-1:0]        own_y_i,
   input  logic [`MC_CREDIT_W-1:0]   credit_limit_i,
   input  logic                      credit_v_i,
   output logic                      out_v_o,
   output mc_pkt_pkg::mc_packet_s    out_packet_o,
   input  logic                      out_ready_i
);
   import mc_cfg_pkg::*;

   mc_host_cmd_s            head;
   logic                    head_v;
   logic                    send;
   logic [`MC_CREDIT_W-1:0] outstanding_r;

   mc_fifo #(.payload_t(mc_host_cmd_s), .els_p(`MC_CMD_ELS)) u_cmd_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (cmd_v_i),
      .data_i  (cmd_i),
      .ready_o (cmd_ready_o),
      .v_o     (head_v),
      .data_o  (head),
      .yumi_i  (send)
   );

   // offer the head only with a free credit
   assign out_v_o = head_v & (outstanding_r < credit_limit_i);
   assign send    = out_v_o & out_ready_i;

   assign out_packet_o.data              = head.data;
   assign out_packet_o.addr              = head.addr;
   assign out_packet_o.x_cord            = head.x_cord;
   assign out_packet_o.y_cord            = head.y_cord;
   assign out_packet_o.return_pkt.x_cord = own_x_i;
   assign out_packet_o.return_pkt.y_cord = own_y_i;

   // rises per transfer, falls per returned credit
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         outstanding_r <= '0;
      end else if (send && !credit_v_i) begin
         outstanding_r <= outstanding_r + 1'b1;
      end else if (!send && credit_v_i && outstanding_r != '0) begin
         outstanding_r <= outstanding_r - 1'b1;
      end
   end

endmodule

/* source/mc_node_csr.sv */
`timescale 1ns/10ps
`include "mc_defs.svh"

module mc_node_csr (
   input  logic                         clk_i,
   input  logic                         reset_i,
   input  logic                         csr_we_i,
   input  mc_cfg_pkg::mc_csr_addr_e     csr_addr_i,
   input  logic [`MC_X_W+`MC_Y_W-1:0]   csr_wdata_i,
   output logic [`MC_X_W-1:0]           own_x_o,
   output logic [`MC_Y_W-1:0]           own_y_o,
   output logic [`MC_CREDIT_W-1:0]      credit_limit_o
);
   import mc_cfg_pkg::*;

   logic [`MC_X_W-1:0]      own_x_r;
   logic [`MC_Y_W-1:0]      own_y_r;
   logic [`MC_CREDIT_W-1:0] limit_r;
   logic [`MC_CREDIT_W-1:0] limit_wdata;

   // a limit of zero would never let a packet out
   assign limit_wdata = (csr_wdata_i[`MC_CREDIT_W-1:0] == '0) ?
                        `MC_CREDIT_W'(1) : csr_wdata_i[`MC_CREDIT_W-1:0];

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         own_x_r <= '0;
         own_y_r <= '0;
         limit_r <= `MC_CREDIT_W'(1);
      end else if (csr_we_i) begin
         // coordinates packed as {y, x}
         if (csr_addr_i == MC_CSR_CORD) begin
            own_x_r <= csr_wdata_i[`MC_X_W-1:0];
            own_y_r <= csr_wdata_i[`MC_X_W+`MC_Y_W-1:`MC_X_W];
         end else begin
            limit_r <= limit_wdata;
         end
      end
   end

   assign own_x_o        = own_x_r;
   assign own_y_o        = own_y_r;
   assign credit_limit_o = limit_r;

endmodule

/* source/mc_node_top.sv */
`timescale 1ns/10ps
`include "mc_defs.svh"

module mc_node_top (
   input  logic                          clk_i,
   input  logic                          reset_i,
   input  logic                          link_fwd_v_i,
   input  mc_pkt_pkg::mc_packet_s        link_fwd_data_i,
   output logic                          link_fwd_ready_o,
   output logic                          link_fwd_v_o,
   output mc_pkt_pkg::mc_packet_s        link_fwd_data_o,
   input  logic                          link_fwd_ready_i,
   input  logic                          link_rev_v_i,
   input  logic                          link_rev_ready_i,
   output logic                          link_rev_v_o,
   output mc_pkt_pkg::mc_return_pkt_s    link_rev_data_o,
   input  logic                          cmd_v_i,
   input  mc_cfg_pkg::mc_host_cmd_s      cmd_i,
   output logic                          cmd_ready_o,
   input  logic                          csr_we_i,
   input  mc_cfg_pkg::mc_csr_addr_e      csr_addr_i,
   input  logic [`MC_X_W+`MC_Y_W-1:0]    csr_wdata_i,
   input  logic [`MC_ADDR_W-1:0]         rd_addr_i,
   output logic [`MC_DATA_W-1:0]         rd_data_o
);
   import mc_pkt_pkg::*;

   logic                    fifo_v;
   mc_packet_s              fifo_data;
   logic                    fifo_yumi;
   logic                    out_v;
   mc_packet_s              out_packet;
   logic                    out_ready;
   logic                    credit_v;
   logic [`MC_X_W-1:0]      own_x;
   logic [`MC_Y_W-1:0]      own_y;
   logic [`MC_CREDIT_W-1:0] credit_limit;

   mc_endpoint u_endpoint (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .link_fwd_v_i     (link_fwd_v_i),
      .link_fwd_data_i  (link_fwd_data_i),
      .link_fwd_ready_o (link_fwd_ready_o),
      .link_fwd_v_o     (link_fwd_v_o),
      .link_fwd_data_o  (link_fwd_data_o),
      .link_fwd_ready_i (link_fwd_ready_i),
      .link_rev_v_i     (link_rev_v_i),
      .link_rev_ready_i (link_rev_ready_i),
      .link_rev_v_o     (link_rev_v_o),
      .link_rev_data_o  (link_rev_data_o),
      .fifo_v_o         (fifo_v),
      .fifo_data_o      (fifo_data),
      .fifo_yumi_i      (fifo_yumi),
      .out_v_i          (out_v),
      .out_packet_i     (out_packet),
      .out_ready_o      (out_ready),
      .credit_v_o       (credit_v)
   );

   mc_store u_store (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .req_v_i    (fifo_v),
      .req_i      (fifo_data),
      .req_yumi_o (fifo_yumi),
      .rd_addr_i  (rd_addr_i),
      .rd_data_o  (rd_data_o)
   );

   mc_node_csr u_csr (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .csr_we_i       (csr_we_i),
      .csr_addr_i     (csr_addr_i),
      .csr_wdata_i    (csr_wdata_i),
      .own_x_o        (own_x),
      .own_y_o        (own_y),
      .credit_limit_o (credit_limit)
   );

   mc_injector u_injector (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .cmd_v_i        (cmd_v_i),
      .cmd_i          (cmd_i),
      .cmd_ready_o    (cmd_ready_o),
      .own_x_i        (own_x),
      .own_y_i        (own_y),
      .credit_limit_i (credit_limit),
      .credit_v_i     (credit_v),
      .out_v_o        (out_v),
      .out_packet_o   (out_packet),
      .out_ready_i    (out_ready)
   );

endmodule

/* source/mc_pkt_pkg.sv */
`include "mc_defs.svh"

package mc_pkt_pkg;

   // requester to be credited
   typedef struct packed {
      logic [`MC_Y_W-1:0] y_cord;
      logic [`MC_X_W-1:0] x_cord;
   } mc_return_pkt_s;

   // one-word store request on the forward link
   typedef struct packed {
      mc_return_pkt_s        return_pkt;
      logic [`MC_Y_W-1:0]    y_cord;
      logic [`MC_X_W-1:0]    x_cord;
      logic [`MC_ADDR_W-1:0] addr;
      logic [`MC_DATA_W-1:0] data;
   } mc_packet_s;

endpackage

/* source/mc_store.sv */
`timescale 1ns/10ps
`include "mc_defs.svh"

module mc_store (
   input  logic                    clk_i,
   input  logic                    reset_i,
   input  logic                    req_v_i,
   input  mc_pkt_pkg::mc_packet_s  req_i,
   output logic                    req_yumi_o,
   input  logic [`MC_ADDR_W-1:0]   rd_addr_i,
   output logic [`MC_DATA_W-1:0]   rd_data_o
);

   localparam int words_lp = 1 << `MC_ADDR_W;

   logic [`MC_DATA_W-1:0] mem_r [words_lp];

   // never stalls, takes the request as soon as it shows
   assign req_yumi_o = req_v_i;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int i = 0; i < words_lp; i++) begin
            mem_r[i] <= '0;
         end
      end else if (req_yumi_o) begin
         mem_r[req_i.addr] <= req_i.data;
      end
   end

   // host read port
   assign rd_data_o = mem_r[rd_addr_i];

endmodule

/* src.f */
+incdir+source
source/mc_pkt_pkg.sv
source/mc_cfg_pkg.sv
source/mc_fifo.sv
source/mc_endpoint.sv
source/mc_node_csr.sv
source/mc_injector.sv
source/mc_store.sv
source/mc_node_top.sv
tests/mc_node_properties.sv
tests/mc_node_tb.sv

/* tests/mc_node_properties.sv */
`timescale 1ns/10ps
`include "mc_defs.svh"

module mc_node_properties (
   input logic                    clk_i,
   input logic                    reset_i,
   input logic                    fwd_v_i,
   input logic                    fwd_ready_i,
   input mc_pkt_pkg::mc_packet_s  fwd_data_i,
   input logic                    rev_v_i,
   input logic                    rev_ready_i,
   input logic [`MC_CREDIT_W-1:0] outstanding_i,
   input logic [`MC_CREDIT_W-1:0] credit_limit_i
);

   // stalled forward packet is held until the mesh takes it
   fwd_hold_a : assert property (@(posedge clk_i) disable iff (reset_i)
      fwd_v_i && !fwd_ready_i |=> fwd_v_i && $stable(fwd_data_i))
      else $error("forward valid dropped or data changed while stalled");

   // credits go out only when the mesh can take them
   rev_ready_a : assert property (@(posedge clk_i) disable iff (reset_i)
      !rev_ready_i |-> !rev_v_i)
      else $error("credit pulse sent while reverse link not ready");

   credit_bound_a : assert property (@(posedge clk_i) disable iff (reset_i)
      outstanding_i <= credit_limit_i)
      else $error("outstanding packets exceed the credit limit");

endmodule

/* tests/mc_node_tb.sv */
`timescale 1ns/10ps
`include "mc_defs.svh"

module mc_node_tb;
   import mc_pkt_pkg::*;
   import mc_cfg_pkg::*;

   typedef enum {
      OP_IDLE, OP_CSR, OP_CMD, OP_PKT, OP_CREDIT, OP_REVRDY, OP_FWD, OP_REV, OP_MEM, OP_RDY
   } op_kind_e;

   // dst and ret are coordinates packed as {y, x}
   typedef struct {
      op_kind_e              kind;
      logic [`MC_ADDR_W-1:0] a;
      logic [`MC_DATA_W-1:0] d;
      logic [5:0]            dst;
      logic [5:0]            ret;
      int                    n;
   } op_t;

   logic                       clk_i;
   logic                       reset_i;
   logic                       link_fwd_v_i;
   mc_packet_s                 link_fwd_data_i;
   logic                       link_fwd_ready_o;
   logic                       link_fwd_v_o;
   mc_packet_s                 link_fwd_data_o;
   logic                       link_fwd_ready_i;
   logic                       link_rev_v_i;
   logic                       link_rev_ready_i;
   logic                       link_rev_v_o;
   mc_return_pkt_s             link_rev_data_o;
   logic                       cmd_v_i;
   mc_host_cmd_s               cmd_i;
   logic                       cmd_ready_o;
   logic                       csr_we_i;
   mc_csr_addr_e               csr_addr_i;
   logic [`MC_X_W+`MC_Y_W-1:0] csr_wdata_i;
   logic [`MC_ADDR_W-1:0]      rd_addr_i;
   logic [`MC_DATA_W-1:0]      rd_data_o;

   op_t        table_q[$];
   mc_packet_s exp_fwd_q[$];
   mc_packet_s fwd_got_q[$];
   logic [5:0] exp_rev_q[$];
   logic [5:0] rev_got_q[$];
   int         fwd_cnt = 0;
   int         rev_cnt = 0;
   int         cycles = 0;
   int         cycle_limit = 0;
   int         mismatches = 0;
   logic [31:0] ready_pat;

   mc_node_top u_dut (.*);

   bind mc_node_top mc_node_properties u_props (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .fwd_v_i        (link_fwd_v_o),
      .fwd_ready_i    (link_fwd_ready_i),
      .fwd_data_i     (link_fwd_data_o),
      .rev_v_i        (link_rev_v_o),
      .rev_ready_i    (link_rev_ready_i),
      .outstanding_i  (u_injector.outstanding_r),
      .credit_limit_i (credit_limit)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   task automatic report_fail();
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
         report_fail();
      end
   endtask

   function automatic mc_packet_s make_pkt(logic [31:0] d, logic [3:0] a,
                                           logic [5:0] dst, logic [5:0] ret);
      mc_packet_s p;
      p.data              = d;
      p.addr              = a;
      p.x_cord            = dst[`MC_X_W-1:0];
      p.y_cord            = dst[5:`MC_X_W];
      p.return_pkt.x_cord = ret[`MC_X_W-1:0];
      p.return_pkt.y_cord = ret[5:`MC_X_W];
      return p;
   endfunction

   function automatic void add_op(op_kind_e kind, logic [3:0] a, logic [31:0] d,
                                  logic [5:0] dst, logic [5:0] ret, int n);
      op_t op;
      op.kind = kind;
      op.a    = a;
      op.d    = d;
      op.dst  = dst;
      op.ret  = ret;
      op.n    = n;
      table_q.push_back(op);
   endfunction

   // timeout
   always @(posedge clk_i) begin
      cycles++;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         report_fail();
      end
   end

   // mesh ready with a fixed random stall pattern
   always @(posedge clk_i) begin
      #1;
      link_fwd_ready_i = ready_pat[cycles % 32];
   end

   // mesh model, sampled mid-cycle where the link is stable
   always @(negedge clk_i) begin
      if (!reset_i) begin
         if (link_fwd_v_o && link_fwd_ready_i) begin
            fwd_got_q.push_back(link_fwd_data_o);
            fwd_cnt++;
         end
         if (link_rev_v_o) begin
            rev_got_q.push_back(link_rev_data_o);
            rev_cnt++;
         end
      end
   end

   task automatic apply_op(input op_t op);
      mc_packet_s got_pkt;
      logic [5:0] got_ret;
      case (op.kind)
         OP_IDLE: begin
            check(link_fwd_v_o, 1'b0, "forward valid after reset");
            check(link_rev_v_o, 1'b0, "credit valid after reset");
            check(cmd_ready_o, 1'b1, "command ready after reset");
            for (int i = 0; i < (1 << `MC_ADDR_W); i++) begin
               rd_addr_i = i;
               #1;
               check(rd_data_o, '0, "memory word after reset");
               @(posedge clk_i);
               #1;
            end
         end
         OP_CSR: begin
            csr_we_i    = 1'b1;
            csr_addr_i  = mc_csr_addr_e'(op.a[0]);
            csr_wdata_i = op.d[5:0];
            @(posedge clk_i);
            #1;
            csr_we_i = 1'b0;
         end
         OP_CMD: begin
            while (!cmd_ready_o) begin
               @(posedge clk_i);
               #1;
            end
            cmd_i.data   = op.d;
            cmd_i.addr   = op.a;
            cmd_i.x_cord = op.dst[`MC_X_W-1:0];
            cmd_i.y_cord = op.dst[5:`MC_X_W];
            cmd_v_i      = 1'b1;
            @(posedge clk_i);
            #1;
            cmd_v_i = 1'b0;
            exp_fwd_q.push_back(make_pkt(op.d, op.a, op.dst, op.ret));
         end
         OP_PKT: begin
            link_fwd_data_i = make_pkt(op.d, op.a, op.dst, op.ret);
            link_fwd_v_i    = 1'b1;
            while (!link_fwd_ready_o) begin
               @(posedge clk_i);
               #1;
            end
            @(posedge clk_i);
            #1;
            link_fwd_v_i = 1'b0;
            exp_rev_q.push_back(op.ret);
         end
         OP_CREDIT: begin
            link_rev_v_i = 1'b1;
            @(posedge clk_i);
            #1;
            link_rev_v_i = 1'b0;
         end
         OP_REVRDY: link_rev_ready_i = op.d[0];
         OP_FWD: begin
            while (fwd_cnt < op.n)
               @(posedge clk_i);
            // quiet window, no extra packet may follow
            repeat (16) @(posedge clk_i);
            #1;
            check(fwd_cnt, op.n, "forward packet count");
            while (fwd_got_q.size() > 0) begin
               got_pkt = fwd_got_q.pop_front();
               check(exp_fwd_q.size() != 0, 1'b1, "forward packet was expected");
               check(got_pkt, exp_fwd_q.pop_front(), "forward packet");
            end
         end
         OP_REV: begin
            while (rev_cnt < op.n)
               @(posedge clk_i);
            repeat (16) @(posedge clk_i);
            #1;
            check(rev_cnt, op.n, "credit pulse count");
            while (rev_got_q.size() > 0) begin
               got_ret = rev_got_q.pop_front();
               check(exp_rev_q.size() != 0, 1'b1, "credit pulse was expected");
               check(got_ret, exp_rev_q.pop_front(), "credit return coordinates");
            end
         end
         OP_MEM: begin
            rd_addr_i = op.a;
            #1;
            check(rd_data_o, op.d, "memory word");
         end
         OP_RDY: check(link_fwd_ready_o, op.d[0], "incoming queue ready");
         default: ;
      endcase
   endtask

   initial begin
      logic [31:0] w0;
      logic [31:0] w1;
      logic [31:0] w2;
      logic [31:0] w3;
      void'($urandom(32'hd0f78dfb));
      ready_pat = $urandom | $urandom | 32'h1;
      w0 = $urandom;
      w1 = $urandom;
      w2 = $urandom;
      w3 = $urandom;

      reset_i          = 1'b1;
      link_fwd_v_i     = 1'b0;
      link_fwd_data_i  = '0;
      link_fwd_ready_i = 1'b1;
      link_rev_v_i     = 1'b0;
      link_rev_ready_i = 1'b1;
      cmd_v_i          = 1'b0;
      cmd_i            = '0;
      csr_we_i         = 1'b0;
      csr_addr_i       = MC_CSR_CORD;
      csr_wdata_i      = '0;
      rd_addr_i        = '0;

      // own node at x 3, y 5
      add_op(OP_IDLE, 4'h0, 32'h0, 6'h00, 6'h00, 0);
      add_op(OP_CSR, 4'h0, 32'h2b, 6'h00, 6'h00, 0);
      add_op(OP_CSR, 4'h1, 32'h7, 6'h00, 6'h00, 0);
      add_op(OP_CMD, 4'h1, $urandom, 6'h0a, 6'h2b, 0);
      add_op(OP_CMD, 4'h2, $urandom, 6'h11, 6'h2b, 0);
      add_op(OP_CMD, 4'hf, $urandom, 6'h3f, 6'h2b, 0);
      add_op(OP_FWD, 4'h0, 32'h0, 6'h00, 6'h00, 3);
      repeat (3) add_op(OP_CREDIT, 4'h0, 32'h0, 6'h00, 6'h00, 0);
      // incoming stores, one credit each
      add_op(OP_PKT, 4'h3, w0, 6'h2b, 6'h0a, 0);
      add_op(OP_REV, 4'h0, 32'h0, 6'h00, 6'h00, 1);
      add_op(OP_MEM, 4'h3, w0, 6'h00, 6'h00, 0);
      add_op(OP_PKT, 4'h9, w1, 6'h2b, 6'h31, 0);
      add_op(OP_REV, 4'h0, 32'h0, 6'h00, 6'h00, 2);
      add_op(OP_MEM, 4'h9, w1, 6'h00, 6'h00, 0);
      // limit of two, third packet waits for a credit
      add_op(OP_CSR, 4'h1, 32'h2, 6'h00, 6'h00, 0);
      add_op(OP_CMD, 4'h4, $urandom, 6'h01, 6'h2b, 0);
      add_op(OP_CMD, 4'h5, $urandom, 6'h08, 6'h2b, 0);
      add_op(OP_CMD, 4'h6, $urandom, 6'h24, 6'h2b, 0);
      add_op(OP_FWD, 4'h0, 32'h0, 6'h00, 6'h00, 5);
      add_op(OP_CREDIT, 4'h0, 32'h0, 6'h00, 6'h00, 0);
      add_op(OP_FWD, 4'h0, 32'h0, 6'h00, 6'h00, 6);
      repeat (2) add_op(OP_CREDIT, 4'h0, 32'h0, 6'h00, 6'h00, 0);
      // reverse link blocked, requests stay queued
      add_op(OP_REVRDY, 4'h0, 32'h0, 6'h00, 6'h00, 0);
      add_op(OP_PKT, 4'h5, w2, 6'h2b, 6'h01, 0);
      add_op(OP_PKT, 4'h6, w3, 6'h2b, 6'h17, 0);
      add_op(OP_RDY, 4'h0, 32'h0, 6'h00, 6'h00, 0);
      add_op(OP_REV, 4'h0, 32'h0, 6'h00, 6'h00, 2);
      add_op(OP_MEM, 4'h5, 32'h0, 6'h00, 6'h00, 0);
      add_op(OP_MEM, 4'h6, 32'h0, 6'h00, 6'h00, 0);
      add_op(OP_REVRDY, 4'h0, 32'h1, 6'h00, 6'h00, 0);
      add_op(OP_REV, 4'h0, 32'h0, 6'h00, 6'h00, 4);
      add_op(OP_MEM, 4'h5, w2, 6'h00, 6'h00, 0);
      add_op(OP_MEM, 4'h6, w3, 6'h00, 6'h00, 0);
      cycle_limit = 40 * table_q.size();

      repeat (3) @(posedge clk_i);
      #1;
      reset_i = 1'b0;

      foreach (table_q[i])
         apply_op(table_q[i]);

      if (mismatches == 0) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         report_fail();
      end
   end

endmodule
